//--- flist.f
+incdir+include
hw/trig_pkg.sv
hw/trig_regs.sv
hw/trig_input_cond.sv
hw/trig_accept.sv
hw/trig_data_fifo.sv
hw/trig_controller_top.sv
test/tb_trig_controller.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f \
    --top-module tb_trig_controller -Mdir obj_dir -o sim_trig
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/sim_trig)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^ALL TESTS PASSED$"; then
    exit 0
fi
exit 1

//--- test/tb_trig_controller.sv
// testbench for the trigger controller: clock, reset, bus tasks, stimulus table and checks
`timescale 1ns/1ps

module tb_trig_controller;

    typedef struct packed {
        logic        en;
        logic [7:0]  sel, inv, vsel, trig, veto;
        logic [1:0]  fmt;   // 0 number, 1 timestamp, 2 combined
        logic [31:0] max, preset;
        int          pulses, acc, words, lost;
    } row_t;

    logic        BUS_CLK = 1'b0;
    logic        RST;
    logic [15:0] BUS_ADD;
    logic [7:0]  BUS_DATA_IN;
    logic        BUS_RD;
    logic        BUS_WR;
    logic [7:0]  BUS_DATA_OUT;
    logic [7:0]  TRIGGER;
    logic [7:0]  TRIGGER_VETO;
    logic        EXT_TRIGGER_ENABLE;
    logic        TRIGGER_ACCEPTED_FLAG;
    logic        FIFO_READ;
    logic        FIFO_EMPTY;
    logic [31:0] FIFO_DATA;
    logic [31:0] TIMESTAMP;

    row_t rows [$];
    int   errors = 0;
    int   failed_tests = 0;
    int   cycles = 0;
    int   cycle_limit = 0;  // set once the table is loaded
    int   flags_seen = 0;

    trig_controller_top UUT (.*);

    always #20 BUS_CLK = ~BUS_CLK;

    // watchdog and accepted-flag counter
    always @(posedge BUS_CLK)
    begin
        cycles <= cycles + 1;
        if (TRIGGER_ACCEPTED_FLAG)
            flags_seen <= flags_seen + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit)
        begin
            $display("timeout: run still busy after %0d cycles", cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic add_row(input logic en, input logic [7:0] sel, inv, vsel, trig, veto,
                           input logic [1:0] fmt, input logic [31:0] max, preset,
                           input int pulses, acc, words, lost);
        rows.push_back(row_t'({en, sel, inv, vsel, trig, veto, fmt, max, preset,
                               pulses, acc, words, lost}));
    endtask

    task automatic write_reg(input logic [15:0] addr, input logic [7:0] data);
        @(posedge BUS_CLK);
        BUS_ADD     <= addr;
        BUS_DATA_IN <= data;
        BUS_WR      <= 1'b1;
        @(posedge BUS_CLK);
        BUS_WR      <= 1'b0;
    endtask

    task automatic read_reg(input logic [15:0] addr, output logic [7:0] data);
        @(posedge BUS_CLK);
        BUS_ADD <= addr;
        BUS_RD  <= 1'b1;
        @(posedge BUS_CLK);
        BUS_RD  <= 1'b0;
        @(negedge BUS_CLK);
        data = BUS_DATA_OUT;    // registered on the RD edge
    endtask

    // address 5 first, it latches the upper bytes
    task automatic read_count(output logic [31:0] value);
        logic [7:0] b;
        for (int i = 0; i < 4; i++)
        begin
            read_reg(16'(5 + i), b);
            value[8*i +: 8] = b;
        end
    endtask

    task automatic expect_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic pulse(input logic [7:0] pattern, input logic [7:0] idle);
        int width;
        width = 1 + ($urandom % 4);
        @(posedge BUS_CLK);
        TRIGGER <= pattern;
        repeat (width) @(posedge BUS_CLK);
        TRIGGER <= idle;
        repeat (12) @(posedge BUS_CLK);     // word is in the FIFO well before this
    endtask

    task automatic drain(input row_t r);
        int          n;
        logic [31:0] word;
        logic [31:0] num;
        logic [31:0] prev_ts;
        n = 0;
        prev_ts = 0;
        @(negedge BUS_CLK);
        while (!FIFO_EMPTY && n < 16)
        begin
            word = FIFO_DATA;
            num  = r.preset + 32'(n) + 1;   // numbers start one above the preset
            expect_eq("marker bit", 32'(word[31]), 1);
            case (r.fmt)
                // pulses are at least 12 cycles apart
                2'd1:    expect_eq("timestamp spacing", 32'(word[30:0] >= prev_ts + 12), 1);
                2'd2:    expect_eq("combined number", 32'(word[15:0]), 32'(num[15:0]));
                default: expect_eq("trigger number", 32'(word[30:0]), 32'(num[30:0]));
            endcase
            prev_ts = 32'(word[30:0]);
            n++;
            @(posedge BUS_CLK);
            FIFO_READ <= 1'b1;
            @(posedge BUS_CLK);
            FIFO_READ <= 1'b0;
            @(negedge BUS_CLK);
        end
        expect_eq("FIFO word count", n, r.words);
    endtask

    task automatic report(input int num, input int errs);
        if (errs == 0)
            $display("test %0d: ok", num);
        else
        begin
            $display("test %0d: %0d errors", num, errs);
            failed_tests++;
        end
    endtask

    initial
    begin
        logic [7:0]  rd;
        logic [31:0] cnt;
        int          errs_at_start;
        int          flags_at_start;

        void'($urandom(32'h2661_459b));
        RST                <= 1'b1;
        BUS_ADD            <= '0;
        BUS_DATA_IN        <= '0;
        BUS_RD             <= 1'b0;
        BUS_WR             <= 1'b0;
        TRIGGER            <= '0;
        TRIGGER_VETO       <= '0;
        EXT_TRIGGER_ENABLE <= 1'b0;
        FIFO_READ          <= 1'b0;

        //      en sel    inv    vsel   trig   veto  fmt max preset pulses acc words lost
        add_row(0, 8'h01, 8'h00, 8'h00, 8'h01, 8'h00, 0, 0, 0,    2,  0,  0, 0);  // disabled
        add_row(1, 8'h01, 8'h00, 8'h00, 8'h01, 8'h00, 0, 0, 0,    3,  3,  3, 0);
        add_row(1, 8'h02, 8'h00, 8'h00, 8'h01, 8'h00, 0, 0, 0,    2,  0,  0, 0);  // masked
        add_row(1, 8'h04, 8'h04, 8'h00, 8'h00, 8'h00, 1, 0, 0,    2,  2,  2, 0);  // inverted
        add_row(1, 8'h01, 8'h00, 8'h01, 8'h01, 8'h01, 0, 0, 0,    2,  0,  0, 0);  // vetoed
        add_row(1, 8'h11, 8'h00, 8'h02, 8'h10, 8'h01, 2, 0, 0,    2,  2,  2, 0);
        add_row(1, 8'h01, 8'h00, 8'h00, 8'h01, 8'h00, 0, 3, 0,    5,  3,  3, 0);  // limit
        add_row(1, 8'h01, 8'h00, 8'h00, 8'h01, 8'h00, 0, 0, 1000, 3,  3,  3, 0);
        add_row(1, 8'h01, 8'h00, 8'h00, 8'h01, 8'h00, 0, 0, 0,    10, 10, 8, 2);  // overflow
        foreach (rows[i])
            cycle_limit += rows[i].pulses * 12 + 100;
        cycle_limit += 12 + 100 + 200;  // soft reset test and margin

        repeat (10) @(posedge BUS_CLK);
        RST <= 1'b0;
        errs_at_start = errors;
        read_reg(16'd0, rd);
        expect_eq("version", 32'(rd), 9);
        read_reg(16'd1, rd);
        expect_eq("configuration", 32'(rd), 0);
        expect_eq("FIFO_EMPTY after reset", 32'(FIFO_EMPTY), 1);
        expect_eq("accepted flag after reset", 32'(TRIGGER_ACCEPTED_FLAG), 0);
        report(0, errors - errs_at_start);

        foreach (rows[i])
        begin
            row_t r;
            r = rows[i];
            errs_at_start = errors;
            write_reg(16'd0, 8'h00);    // soft reset between rows
            TRIGGER      <= r.inv;      // idle level
            TRIGGER_VETO <= r.veto;
            write_reg(16'd4, r.inv);    // invert before select keeps the OR low
            write_reg(16'd2, r.sel);
            write_reg(16'd3, r.vsel);
            for (int b = 0; b < 4; b++)
                write_reg(16'(9 + b), r.max[8*b +: 8]);
            if (r.preset != 0)
                for (int b = 0; b < 4; b++)
                    write_reg(16'(5 + b), r.preset[8*b +: 8]);
            write_reg(16'd1, {5'd0, r.fmt, r.en});
            repeat (8) @(negedge BUS_CLK);
            flags_at_start = flags_seen;
            repeat (r.pulses)
                pulse(r.trig, r.inv);
            read_count(cnt);
            expect_eq("trigger counter", cnt, r.preset + 32'(r.acc));
            expect_eq("accepted flags", flags_seen - flags_at_start, r.acc);
            read_reg(16'd13, rd);
            expect_eq("lost count", 32'(rd), r.lost);
            drain(r);
            report(i + 1, errors - errs_at_start);
        end

        // last row stays configured, leave one word behind and soft reset
        errs_at_start = errors;
        pulse(8'h01, 8'h00);
        @(negedge BUS_CLK);
        expect_eq("FIFO_EMPTY before soft reset", 32'(FIFO_EMPTY), 0);
        write_reg(16'd0, 8'h00);
        @(negedge BUS_CLK);
        expect_eq("TIMESTAMP after soft reset", TIMESTAMP, 0);
        repeat (3) @(negedge BUS_CLK);
        expect_eq("TIMESTAMP three cycles later", TIMESTAMP, 3);    // free running
        read_count(cnt);
        expect_eq("counter after soft reset", cnt, 0);
        read_reg(16'd13, rd);
        expect_eq("lost count after soft reset", 32'(rd), 0);
        expect_eq("FIFO_EMPTY after soft reset", 32'(FIFO_EMPTY), 1);
        report(rows.size() + 1, errors - errs_at_start);

        $display("%0d tests, %0d failed, %0d errors", rows.size() + 2, failed_tests, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- hw/trig_controller_top.sv
// trigger controller top level with bus, trigger and FIFO ports
`timescale 1ns/1ps
`include "trig_cfg.svh"

module trig_controller_top
    import trig_pkg::*;
(
    input  logic                    BUS_CLK,
    input  logic                    RST,
    input  logic [`TRIG_ADDR_W-1:0] BUS_ADD,
    input  logic [`TRIG_DATA_W-1:0] BUS_DATA_IN,
    input  logic                    BUS_RD,
    input  logic                    BUS_WR,
    output logic [`TRIG_DATA_W-1:0] BUS_DATA_OUT,
    input  logic [`TRIG_IN_W-1:0]   TRIGGER,
    input  logic [`TRIG_IN_W-1:0]   TRIGGER_VETO,
    input  logic                    EXT_TRIGGER_ENABLE,
    output logic                    TRIGGER_ACCEPTED_FLAG,
    input  logic                    FIFO_READ,
    output logic                    FIFO_EMPTY,
    output logic [31:0]             FIFO_DATA,
    output logic [`TRIG_CNT_W-1:0]  TIMESTAMP
);

    logic                   soft_rst;
    logic                   rst_int;    // hard or soft reset for the stages
    trig_cfg_t              cfg;
    logic                   cnt_set;
    logic [`TRIG_CNT_W-1:0] cnt_set_value;
    logic [`TRIG_CNT_W-1:0] trig_count;
    logic [7:0]             lost_count;
    logic                   trig_edge;
    logic                   veto;
    logic                   ev_valid;
    trig_event_t            ev;

    assign rst_int = RST | soft_rst;

    trig_regs regs_i (
        .BUS_CLK(BUS_CLK), .RST(RST),
        .bus_add(BUS_ADD), .bus_data_in(BUS_DATA_IN),
        .bus_rd(BUS_RD), .bus_wr(BUS_WR), .bus_data_out(BUS_DATA_OUT),
        .cfg(cfg), .cnt_set(cnt_set), .cnt_set_value(cnt_set_value),
        .trig_count(trig_count), .lost_count(lost_count), .soft_rst(soft_rst)
    );

    trig_input_cond input_cond_i (
        .BUS_CLK(BUS_CLK), .rst(rst_int),
        .trigger(TRIGGER), .trigger_veto(TRIGGER_VETO), .cfg(cfg),
        .trig_edge(trig_edge), .veto(veto)
    );

    trig_accept accept_i (
        .BUS_CLK(BUS_CLK), .rst(rst_int),
        .trig_edge(trig_edge), .veto(veto), .ext_enable(EXT_TRIGGER_ENABLE), .cfg(cfg),
        .cnt_set(cnt_set), .cnt_set_value(cnt_set_value),
        .accepted(TRIGGER_ACCEPTED_FLAG), .ev_valid(ev_valid), .ev(ev),
        .trig_count(trig_count), .timestamp(TIMESTAMP)
    );

    trig_data_fifo data_fifo_i (
        .BUS_CLK(BUS_CLK), .rst(rst_int),
        .ev_valid(ev_valid), .ev(ev), .cfg(cfg), .fifo_read(FIFO_READ),
        .fifo_empty(FIFO_EMPTY), .fifo_data(FIFO_DATA), .lost_count(lost_count)
    );

endmodule

//--- hw/trig_data_fifo.sv
// data word formatting, show-ahead output FIFO and saturating lost-data counter
`timescale 1ns/1ps
`include "trig_cfg.svh"

module trig_data_fifo
    import trig_pkg::*;
(
    input  logic        BUS_CLK,
    input  logic        rst,
    input  logic        ev_valid,
    input  trig_event_t ev,
    input  trig_cfg_t   cfg,
    input  logic        fifo_read,
    output logic        fifo_empty,
    output logic [31:0] fifo_data,
    output logic [7:0]  lost_count
);

    localparam int DEPTH = `TRIG_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    logic [31:0]   mem [0:DEPTH-1];
    logic [AW-1:0] wr_ptr;  // pointers wrap naturally, depth is a power of two
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count_q;
    logic [31:0]   fmt_word;
    logic          full;
    logic          wr_en;
    logic          rd_en;

    always_comb
    begin
        case (cfg.data_format)
            FMT_TIMESTAMP: fmt_word = {1'b0, ev.timestamp[30:0]};
            FMT_COMBINED:  fmt_word = {1'b0, ev.timestamp[14:0], ev.number[15:0]};
            default:       fmt_word = {1'b0, ev.number[30:0]};
        endcase
        fmt_word[`TRIG_MARKER_BIT] = 1'b1;
    end

    assign full       = (count_q == DEPTH[AW:0]);
    assign fifo_empty = (count_q == '0);
    assign wr_en      = ev_valid && !full;
    assign rd_en      = fifo_read && !fifo_empty;   // reads of an empty FIFO are dropped
    assign fifo_data  = mem[rd_ptr];                // head word, show-ahead

    always_ff @(posedge BUS_CLK)
    begin
        if (wr_en)
            mem[wr_ptr] <= fmt_word;
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (rst)
        begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count_q <= '0;
        end
        else
        begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (rst)
            lost_count <= '0;
        else if (ev_valid && full && lost_count != 8'hff)
            lost_count <= lost_count + 1'b1;    // sticks at 255
    end

    // unread head word holds, a write while full would land on it
    a_no_write_full: assert property (@(posedge BUS_CLK) disable iff (rst)
        !fifo_empty && !rd_en |=> fifo_data == $past(fifo_data))
        else $error("FIFO head word overwritten before it was read");

endmodule

//--- hw/trig_accept.sv
// enable and veto gating, trigger counter with preset and limit, timestamp and event output
`timescale 1ns/1ps
`include "trig_cfg.svh"

module trig_accept
    import trig_pkg::*;
(
    input  logic                   BUS_CLK,
    input  logic                   rst,
    input  logic                   trig_edge,
    input  logic                   veto,
    input  logic                   ext_enable,
    input  trig_cfg_t              cfg,
    input  logic                   cnt_set,
    input  logic [`TRIG_CNT_W-1:0] cnt_set_value,
    output logic                   accepted,
    output logic                   ev_valid,
    output trig_event_t            ev,
    output logic [`TRIG_CNT_W-1:0] trig_count,
    output logic [`TRIG_CNT_W-1:0] timestamp
);

    logic [`TRIG_CNT_W-1:0] count_q;
    logic [`TRIG_CNT_W-1:0] ts_q;
    logic                   limit_reached;
    logic                   accept_now;

    assign limit_reached = (cfg.cnt_max != '0) && (count_q >= cfg.cnt_max);
    assign accept_now    = trig_edge && !veto && (cfg.enable || ext_enable) && !limit_reached;

    assign trig_count = count_q;
    assign timestamp  = ts_q;

    always_ff @(posedge BUS_CLK)
    begin
        if (rst)
        begin
            count_q  <= '0;
            ts_q     <= '0;
            accepted <= 1'b0;
            ev_valid <= 1'b0;
        end
        else
        begin
            ts_q     <= ts_q + 1'b1;  // free running
            accepted <= accept_now;
            ev_valid <= accept_now;
            if (cnt_set)
                count_q <= cnt_set_value;   // preset beats a trigger in the same cycle
            else if (accept_now)
                count_q <= count_q + 1'b1;
        end
    end

    // event carries the number after the increment
    always_ff @(posedge BUS_CLK)
    begin
        if (accept_now)
        begin
            ev.number    <= count_q + 1'b1;
            ev.timestamp <= ts_q;
        end
    end

    // flag, event and counter move together unless a preset interfered
    a_accept_event: assert property (@(posedge BUS_CLK) disable iff (rst)
        accepted && !$past(cnt_set) |-> ev_valid && (ev.number == trig_count))
        else $error("accepted trigger without a matching event");

endmodule

//--- hw/trig_input_cond.sv
// trigger invert and select masking, veto masking, synchronizers and rising-edge detection
`timescale 1ns/1ps
`include "trig_cfg.svh"

module trig_input_cond
    import trig_pkg::*;
(
    input  logic                  BUS_CLK,
    input  logic                  rst,
    input  logic [`TRIG_IN_W-1:0] trigger,
    input  logic [`TRIG_IN_W-1:0] trigger_veto,
    input  trig_cfg_t             cfg,
    output logic                  trig_edge,
    output logic                  veto
);

    localparam int STAGES = `TRIG_SYNC_STAGES;

    logic              trig_or;
    logic              veto_or;
    logic [STAGES-1:0] trig_sync;   // bit 0 samples the raw OR
    logic [STAGES-1:0] veto_sync;
    logic              trig_last;

    assign trig_or = |((trigger ^ cfg.trig_invert) & cfg.trig_select);
    assign veto_or = |(trigger_veto & cfg.veto_select);

    always_ff @(posedge BUS_CLK)
    begin
        if (rst)
        begin
            trig_sync <= '0;
            veto_sync <= '0;
            trig_last <= 1'b0;
            trig_edge <= 1'b0;
            veto      <= 1'b0;
        end
        else
        begin
            trig_sync <= {trig_sync[STAGES-2:0], trig_or};
            veto_sync <= {veto_sync[STAGES-2:0], veto_or};
            trig_last <= trig_sync[STAGES-1];
            trig_edge <= trig_sync[STAGES-1] & ~trig_last;
            veto      <= veto_sync[STAGES-1];   // one extra flop, lines up with trig_edge
        end
    end

    a_edge_single: assert property (@(posedge BUS_CLK) disable iff (rst)
        trig_edge |=> !trig_edge)
        else $error("trigger edge pulse lasted two cycles");

endmodule

//--- hw/trig_regs.sv
// register file with bus write and read decode, counter preset pulse and latched counter readback
`timescale 1ns/1ps
`include "trig_cfg.svh"

module trig_regs
    import trig_pkg::*;
(
    input  logic                    BUS_CLK,
    input  logic                    RST,
    input  logic [`TRIG_ADDR_W-1:0] bus_add,
    input  logic [`TRIG_DATA_W-1:0] bus_data_in,
    input  logic                    bus_rd,
    input  logic                    bus_wr,
    output logic [`TRIG_DATA_W-1:0] bus_data_out,
    output trig_cfg_t               cfg,
    output logic                    cnt_set,
    output logic [`TRIG_CNT_W-1:0]  cnt_set_value,
    input  logic [`TRIG_CNT_W-1:0]  trig_count,
    input  logic [7:0]              lost_count,
    output logic                    soft_rst
);

    localparam logic [`TRIG_DATA_W-1:0] VERSION = `TRIG_VERSION;

    logic                    rst_all;
    logic                    cnt_wr;
    logic [`TRIG_DATA_W-1:0] conf_reg;
    logic [`TRIG_DATA_W-1:0] sel_reg;
    logic [`TRIG_DATA_W-1:0] veto_reg;
    logic [`TRIG_DATA_W-1:0] inv_reg;
    logic [`TRIG_DATA_W-1:0] preset_reg [0:2];  // counter bytes 0 to 2
    logic [`TRIG_DATA_W-1:0] max_reg [0:3];
    logic [`TRIG_CNT_W-1:0]  cnt_latch;         // upper bytes for reads of 6 to 8

    assign soft_rst = bus_wr && (bus_add == `TRIG_ADDR_VERSION);
    assign rst_all  = RST || soft_rst;
    assign cnt_wr   = bus_wr && (bus_add == `TRIG_ADDR_CNT + 3);  // top byte loads counter

    assign cfg.enable      = conf_reg[0];
    assign cfg.data_format = trig_format_e'(conf_reg[2:1]);
    assign cfg.trig_select = sel_reg;
    assign cfg.veto_select = veto_reg;
    assign cfg.trig_invert = inv_reg;
    assign cfg.cnt_max     = {max_reg[3], max_reg[2], max_reg[1], max_reg[0]};

    always_ff @(posedge BUS_CLK)
    begin
        if (rst_all)
        begin
            conf_reg <= '0;
            sel_reg  <= '0;
            veto_reg <= '0;
            inv_reg  <= '0;
            for (int i = 0; i < 3; i++)
                preset_reg[i] <= '0;
            for (int i = 0; i < 4; i++)
                max_reg[i] <= '0;
        end
        else if (bus_wr && bus_add <= `TRIG_ADDR_LAST)
        begin
            case (bus_add)
                `TRIG_ADDR_CONF:    conf_reg      <= bus_data_in;
                `TRIG_ADDR_SEL:     sel_reg       <= bus_data_in;
                `TRIG_ADDR_VETO:    veto_reg      <= bus_data_in;
                `TRIG_ADDR_INV:     inv_reg       <= bus_data_in;
                `TRIG_ADDR_CNT:     preset_reg[0] <= bus_data_in;
                `TRIG_ADDR_CNT + 1: preset_reg[1] <= bus_data_in;
                `TRIG_ADDR_CNT + 2: preset_reg[2] <= bus_data_in;
                `TRIG_ADDR_MAX:     max_reg[0]    <= bus_data_in;
                `TRIG_ADDR_MAX + 1: max_reg[1]    <= bus_data_in;
                `TRIG_ADDR_MAX + 2: max_reg[2]    <= bus_data_in;
                `TRIG_ADDR_MAX + 3: max_reg[3]    <= bus_data_in;
                default: ;  // version, counter top byte and lost count
            endcase
        end
    end

    // preset reaches the counter one cycle after the top byte write
    always_ff @(posedge BUS_CLK)
    begin
        if (rst_all)
            cnt_set <= 1'b0;
        else
            cnt_set <= cnt_wr;
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (cnt_wr)
            cnt_set_value <= {bus_data_in, preset_reg[2], preset_reg[1], preset_reg[0]};
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (bus_rd && bus_add == `TRIG_ADDR_CNT)
            cnt_latch <= trig_count;    // snapshot so the four bytes agree
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (bus_rd)
        begin
            case (bus_add)
                `TRIG_ADDR_VERSION: bus_data_out <= VERSION;
                `TRIG_ADDR_CONF:    bus_data_out <= conf_reg;
                `TRIG_ADDR_SEL:     bus_data_out <= sel_reg;
                `TRIG_ADDR_VETO:    bus_data_out <= veto_reg;
                `TRIG_ADDR_INV:     bus_data_out <= inv_reg;
                `TRIG_ADDR_CNT:     bus_data_out <= trig_count[7:0];   // live byte
                `TRIG_ADDR_CNT + 1: bus_data_out <= cnt_latch[15:8];
                `TRIG_ADDR_CNT + 2: bus_data_out <= cnt_latch[23:16];
                `TRIG_ADDR_CNT + 3: bus_data_out <= cnt_latch[31:24];
                `TRIG_ADDR_MAX:     bus_data_out <= max_reg[0];
                `TRIG_ADDR_MAX + 1: bus_data_out <= max_reg[1];
                `TRIG_ADDR_MAX + 2: bus_data_out <= max_reg[2];
                `TRIG_ADDR_MAX + 3: bus_data_out <= max_reg[3];
                `TRIG_ADDR_LOST:    bus_data_out <= lost_count;
                default:            bus_data_out <= '0;
            endcase
        end
    end

    // back-to-back writes of the top counter byte are not allowed on the bus
    a_cnt_set_single: assert property (@(posedge BUS_CLK) cnt_set |=> !cnt_set)
        else $error("counter preset pulse lasted two cycles");

endmodule

//--- hw/trig_pkg.sv
// trigger data format enumeration, configuration struct and trigger event struct
`include "trig_cfg.svh"

package trig_pkg;

    // data word layouts, bit 31 is always the marker
    typedef enum logic [1:0] {
        FMT_NUMBER    = 2'd0,   // 30:0 trigger number
        FMT_TIMESTAMP = 2'd1,   // 30:0 timestamp
        FMT_COMBINED  = 2'd2    // 30:16 timestamp, 15:0 trigger number
    } trig_format_e;            // code 3 formats as a number

    // register contents seen by the stages
    typedef struct packed {
        logic                   enable;
        trig_format_e           data_format;
        logic [`TRIG_IN_W-1:0]  trig_select;
        logic [`TRIG_IN_W-1:0]  veto_select;
        logic [`TRIG_IN_W-1:0]  trig_invert;
        logic [`TRIG_CNT_W-1:0] cnt_max;    // 0 disables the limit
    } trig_cfg_t;

    // one accepted trigger
    typedef struct packed {
        logic [`TRIG_CNT_W-1:0] number;
        logic [`TRIG_CNT_W-1:0] timestamp;
    } trig_event_t;

endpackage

//--- include/trig_cfg.svh
// version, bus widths, fifo depth, marker bit and register addresses of the trigger controller
`ifndef TRIG_CFG_SVH
`define TRIG_CFG_SVH

`define TRIG_VERSION      9     // read back at address 0

`define TRIG_ADDR_W       16
`define TRIG_DATA_W       8
`define TRIG_IN_W         8     // trigger and veto inputs
`define TRIG_CNT_W        32    // trigger counter and timestamp
`define TRIG_FIFO_DEPTH   8     // words, power of two
`define TRIG_SYNC_STAGES  3
`define TRIG_MARKER_BIT   31    // set in every data word

// register map
`define TRIG_ADDR_VERSION 0     // read version, write soft reset
`define TRIG_ADDR_CONF    1
`define TRIG_ADDR_SEL     2
`define TRIG_ADDR_VETO    3
`define TRIG_ADDR_INV     4
`define TRIG_ADDR_CNT     5     // 5 to 8, little-endian
`define TRIG_ADDR_MAX     9     // 9 to 12, little-endian
`define TRIG_ADDR_LOST    13
`define TRIG_ADDR_LAST    13

`endif
